/* hdl/tcdm_bus_pkg.sv */
// Port-level types of the TCDM master interface
// Data word union, master request and response structs
package tcdm_bus_pkg;

    // Bus widths
    localparam int unsigned TCDM_ADDR_W = 32;
    localparam int unsigned TCDM_DATA_W = 32;
    localparam int unsigned TCDM_BE_W   = TCDM_DATA_W / 8;

    // One data word, seen whole or per byte
    // Byte view is what the masked write path uses
    typedef union packed {
        logic [TCDM_DATA_W-1:0]      word;
        logic [TCDM_BE_W-1:0][7:0]   bytes;
    } tcdm_word_u;

    // Master request
    // wen low means write, high means read
    typedef struct packed {
        logic                    req;
        logic                    wen;
        logic [TCDM_ADDR_W-1:0]  add;
        logic [TCDM_BE_W-1:0]    be;
        tcdm_word_u              wdata;
    } tcdm_req_t;

    // Response to the master
    // Single-cycle valid, no back-pressure
    typedef struct packed {
        logic        valid;
        // Address was outside the memory
        logic        err;
        tcdm_word_u  rdata;
    } tcdm_resp_t;

endpackage

/* hdl/tcdm_mem_pkg.sv */
// Bank-side types of the TCDM pipeline
// Width limits for bank index and row, decoded access, read tag
package tcdm_mem_pkg;

    // At most 16 banks
    localparam int unsigned MAX_BANK_IDX_W = 4;
    // At most 4096 words per bank
    localparam int unsigned MAX_ROW_W      = 12;

    // Decoded access, output of stage 1
    typedef struct packed {
        // Strobe for an in-range access only
        logic                                     acc;
        logic                                     wen;
        // Out-of-range request, acc stays low
        logic                                     err;
        logic [MAX_BANK_IDX_W-1:0]                bank;
        logic [MAX_ROW_W-1:0]                     row;
        logic [tcdm_bus_pkg::TCDM_BE_W-1:0]       be;
        tcdm_bus_pkg::tcdm_word_u                 wdata;
    } tcdm_bank_acc_t;

    // Travels beside the SRAM read word, stage 2 to stage 3
    typedef struct packed {
        // A response is owed for this slot
        logic                        rvalid;
        logic                        err;
        // Which bank holds the word
        logic [MAX_BANK_IDX_W-1:0]   bank;
    } tcdm_bank_tag_t;

endpackage

/* hdl/tcdm_req_decode.sv */
// Stage 1 of the TCDM pipeline
// Registers the master request as a decoded bank access
// Word-interleaved bank index and row, out-of-range flag
`timescale 1ns/1ps

module tcdm_req_decode #(
    parameter int unsigned NB_BANKS  = 4,
    parameter int unsigned BANK_SIZE = 256
) (
    input  logic                          clk_i,
    input  logic                          rst_n,
    input  tcdm_bus_pkg::tcdm_req_t       req,
    output tcdm_mem_pkg::tcdm_bank_acc_t  dec_acc
);

    import tcdm_bus_pkg::*;
    import tcdm_mem_pkg::*;

    // Total words across all banks
    localparam int unsigned NB_WORDS = NB_BANKS * BANK_SIZE;

    logic [TCDM_ADDR_W-3:0]     word_addr;
    logic [MAX_BANK_IDX_W-1:0]  bank_idx;
    logic [MAX_ROW_W-1:0]       row;
    logic                       in_range;

    // Byte address to word address
    assign word_addr = req.add[TCDM_ADDR_W-1:2];

    // Low word bits pick the bank, the rest the row
    // Power-of-two sizes, so these reduce to bit slices
    assign bank_idx = MAX_BANK_IDX_W'(word_addr % NB_BANKS);
    assign row      = MAX_ROW_W'(word_addr / NB_BANKS);

    // Anything past the last word of the last row
    assign in_range = (word_addr < NB_WORDS);

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            dec_acc.acc <= 1'b0;
            dec_acc.err <= 1'b0;
        end else begin
            // No bank sees an out-of-range access
            dec_acc.acc <= req.req & in_range;
            dec_acc.err <= req.req & ~in_range;
        end

        // Payload only loads on a request
        if (req.req) begin
            dec_acc.wen   <= req.wen;
            dec_acc.bank  <= bank_idx;
            dec_acc.row   <= row;
            dec_acc.be    <= req.be;
            dec_acc.wdata <= req.wdata;
        end
    end

endmodule

/* hdl/tcdm_bank_sram.sv */
// Behavioral single-port word SRAM
// Byte write enables, registered read word
`timescale 1ns/1ps

module tcdm_bank_sram #(
    parameter int unsigned BANK_SIZE = 256
) (
    input  logic                                 clk_i,
    input  logic                                 ce,
    input  logic                                 wen,
    input  logic [tcdm_bus_pkg::TCDM_BE_W-1:0]   be,
    input  logic [tcdm_mem_pkg::MAX_ROW_W-1:0]   addr,
    input  tcdm_bus_pkg::tcdm_word_u             wdata,
    output tcdm_bus_pkg::tcdm_word_u             rdata
);

    import tcdm_bus_pkg::*;

    // Row bits actually decoded by this bank
    localparam int unsigned ROW_W = (BANK_SIZE > 1) ? $clog2(BANK_SIZE) : 1;

    tcdm_word_u        mem [BANK_SIZE];
    logic [ROW_W-1:0]  row;

    // Upper row bits are zero for any in-range access
    assign row = addr[ROW_W-1:0];

    always_ff @(posedge clk_i) begin
        if (ce) begin
            if (!wen) begin
                // Masked write, one lane per enable
                for (int b = 0; b < TCDM_BE_W; b++) begin
                    if (be[b]) begin
                        mem[row].bytes[b] <= wdata.bytes[b];
                    end
                end
            end else begin
                // Read word held until the next read
                rdata <= mem[row];
            end
        end
    end

endmodule

/* hdl/tcdm_bank_array.sv */
// Stage 2 of the TCDM pipeline
// NB_BANKS word SRAMs, only the addressed one enabled
// Access tag registered alongside the SRAM read
`timescale 1ns/1ps

module tcdm_bank_array #(
    parameter int unsigned NB_BANKS  = 4,
    parameter int unsigned BANK_SIZE = 256
) (
    input  logic                                         clk_i,
    input  logic                                         rst_n,
    input  tcdm_mem_pkg::tcdm_bank_acc_t                 dec_acc,
    output tcdm_bus_pkg::tcdm_word_u [NB_BANKS-1:0]      bank_rdata,
    output tcdm_mem_pkg::tcdm_bank_tag_t                 bank_tag
);

    import tcdm_mem_pkg::*;

    for (genvar i = 0; i < NB_BANKS; i++) begin : gen_bank
        logic bank_ce;

        // Chip enable for a matching bank index
        assign bank_ce = dec_acc.acc && (dec_acc.bank == MAX_BANK_IDX_W'(i));

        tcdm_bank_sram #(
            .BANK_SIZE (BANK_SIZE)
        ) i_bank (
            .clk_i (clk_i),
            .ce    (bank_ce),
            .wen   (dec_acc.wen),
            .be    (dec_acc.be),
            .addr  (dec_acc.row),
            .wdata (dec_acc.wdata),
            .rdata (bank_rdata[i])
        );
    end

    // Same edge as the SRAM read, so tag and word line up
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            bank_tag.rvalid <= 1'b0;
            bank_tag.err    <= 1'b0;
        end else begin
            // In-range reads and every erroring access answer
            bank_tag.rvalid <= (dec_acc.acc & dec_acc.wen) | dec_acc.err;
            bank_tag.err    <= dec_acc.err;
        end

        // Bank index is payload
        bank_tag.bank <= dec_acc.bank;
    end

endmodule

/* hdl/tcdm_resp_select.sv */
// Stage 3 of the TCDM pipeline
// Read word mux over the banks and the registered response
`timescale 1ns/1ps

module tcdm_resp_select #(
    parameter int unsigned NB_BANKS = 4
) (
    input  logic                                      clk_i,
    input  logic                                      rst_n,
    input  tcdm_bus_pkg::tcdm_word_u [NB_BANKS-1:0]   bank_rdata,
    input  tcdm_mem_pkg::tcdm_bank_tag_t              bank_tag,
    output tcdm_bus_pkg::tcdm_resp_t                  resp
);

    import tcdm_bus_pkg::*;

    tcdm_word_u sel_word;

    // Error responses carry a zero word
    assign sel_word = bank_tag.err ? '0 : bank_rdata[bank_tag.bank];

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            resp.valid <= 1'b0;
            resp.err   <= 1'b0;
        end else begin
            // One-cycle pulse per tagged slot
            resp.valid <= bank_tag.rvalid;
            resp.err   <= bank_tag.rvalid & bank_tag.err;
        end

        // Read word only loads with a response
        if (bank_tag.rvalid) begin
            resp.rdata <= sel_word;
        end
    end

endmodule

/* hdl/tcdm_subsystem.sv */
// TCDM subsystem top level, one master port
// Decode, interleaved SRAM banks, response stage
// Three cycles from request to read response
`timescale 1ns/1ps

module tcdm_subsystem #(
    // Powers of two, at most 16 banks of 4096 words
    parameter int unsigned NB_BANKS  = 4,
    parameter int unsigned BANK_SIZE = 256
) (
    input  logic                      clk_i,
    input  logic                      rst_n,
    input  tcdm_bus_pkg::tcdm_req_t   req,
    output tcdm_bus_pkg::tcdm_resp_t  resp
);

    import tcdm_bus_pkg::*;
    import tcdm_mem_pkg::*;

    tcdm_bank_acc_t                dec_acc;
    tcdm_word_u [NB_BANKS-1:0]     bank_rdata;
    tcdm_bank_tag_t                bank_tag;

    // Stage 1, request register and address split
    tcdm_req_decode #(
        .NB_BANKS  (NB_BANKS),
        .BANK_SIZE (BANK_SIZE)
    ) i_req_decode (
        .clk_i   (clk_i),
        .rst_n   (rst_n),
        .req     (req),
        .dec_acc (dec_acc)
    );

    // Stage 2, banks and tag
    tcdm_bank_array #(
        .NB_BANKS  (NB_BANKS),
        .BANK_SIZE (BANK_SIZE)
    ) i_bank_array (
        .clk_i      (clk_i),
        .rst_n      (rst_n),
        .dec_acc    (dec_acc),
        .bank_rdata (bank_rdata),
        .bank_tag   (bank_tag)
    );

    // Stage 3, word select and response
    tcdm_resp_select #(
        .NB_BANKS (NB_BANKS)
    ) i_resp_select (
        .clk_i      (clk_i),
        .rst_n      (rst_n),
        .bank_rdata (bank_rdata),
        .bank_tag   (bank_tag),
        .resp       (resp)
    );

endmodule

/* bench/tcdm_properties.sv */
// Concurrent checks on the TCDM response port, bound into the subsystem
// Reset clearing, read latency, no response for in-range writes
`timescale 1ns/1ps

module tcdm_properties #(
    parameter int unsigned NB_BANKS  = 4,
    parameter int unsigned BANK_SIZE = 256
) (
    input  logic                      clk_i,
    input  logic                      rst_n,
    input  tcdm_bus_pkg::tcdm_req_t   req,
    input  tcdm_bus_pkg::tcdm_resp_t  resp
);

    import tcdm_bus_pkg::*;

    localparam int unsigned NB_WORDS = NB_BANKS * BANK_SIZE;

    // Failed assertions, summed by the testbench at the end
    int unsigned assert_fails = 0;

    logic in_range;

    // Word address against the total memory size
    assign in_range = (req.add[TCDM_ADDR_W-1:2] < NB_WORDS);

    // Any edge in reset leaves the pulse low
    reset_clears_valid: assert property (@(posedge clk_i) !rst_n |=> !resp.valid)
        else begin
            assert_fails++;
            $error("resp.valid high after a clock edge in reset");
        end

    // Every read answers on the third edge, in range or not
    read_gets_response: assert property (@(posedge clk_i) disable iff (!rst_n)
        (req.req && req.wen) |-> ##3 resp.valid)
        else begin
            assert_fails++;
            $error("read request without a response three edges later");
        end

    // In-range writes are silent
    write_no_response: assert property (@(posedge clk_i) disable iff (!rst_n)
        (req.req && !req.wen && in_range) |-> ##3 !resp.valid)
        else begin
            assert_fails++;
            $error("in-range write produced a response");
        end

endmodule

/* bench/tcdm_tb.sv */
// Testbench for the TCDM subsystem
// Clock, reset, stimulus table with expected responses, random traffic
// Shadow memory, response monitor, watchdog and summary
`timescale 1ns/1ps

module tcdm_tb;

    import tcdm_bus_pkg::*;

    // Same values as the subsystem defaults
    localparam int unsigned NB_BANKS  = 4;
    localparam int unsigned BANK_SIZE = 256;
    localparam int unsigned NB_WORDS  = NB_BANKS * BANK_SIZE;
    localparam int unsigned N_RAND    = 400;
    localparam logic        WR        = 1'b0;
    localparam logic        RD        = 1'b1;

    // One table row
    typedef struct packed {
        int           test;
        logic         wen;
        logic [31:0]  add;
        logic [3:0]   be;
        logic [31:0]  wdata;
        logic         rsp;
        logic         err;
        logic [31:0]  rdata;
    } step_t;

    // Response owed by the DUT
    typedef struct packed {
        logic [31:0]  due;
        logic         err;
        logic [31:0]  rdata;
    } exp_t;

    logic         clk_i;
    logic         rst_n;
    tcdm_req_t    req;
    tcdm_resp_t   resp;

    step_t        steps [$];
    exp_t         exp_q [$];
    logic [31:0]  shadow [int unsigned];
    int unsigned  cyc = 0;
    int           n_checks = 0;
    int           n_errors = 0;
    int           chk_base = 0;
    int           err_base = 0;
    integer       seed = 32'h89ca_6284;

    tcdm_subsystem UUT (
        .clk_i (clk_i),
        .rst_n (rst_n),
        .req   (req),
        .resp  (resp)
    );

    bind tcdm_subsystem tcdm_properties #(
        .NB_BANKS  (NB_BANKS),
        .BANK_SIZE (BANK_SIZE)
    ) i_props (
        .clk_i (clk_i),
        .rst_n (rst_n),
        .req   (req),
        .resp  (resp)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Edge count, read on falling edges
    always @(posedge clk_i) begin
        cyc++;
    end

    // Byte-enable rule for the shadow memory
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset";
            2: return "full-word write and read";
            3: return "byte-enable merge";
            4: return "interleaving and pipelining";
            5: return "out of range";
            default: return "random traffic";
        endcase
    endfunction

    task automatic add_step(input int test, input logic wen, input logic [31:0] add,
                            input logic [3:0] be, input logic [31:0] wdata,
                            input logic rsp, input logic err, input logic [31:0] rdata);
        step_t s;
        s = '{test, wen, add, be, wdata, rsp, err, rdata};
        steps.push_back(s);
    endtask

    task automatic build_table();
        // Full words in all four banks, then the last word
        add_step(2, WR, 32'h0000_0000, 4'hF, 32'h1111_0000, 1'b0, 1'b0, 32'h0);
        add_step(2, WR, 32'h0000_0004, 4'hF, 32'h2222_0001, 1'b0, 1'b0, 32'h0);
        add_step(2, WR, 32'h0000_0008, 4'hF, 32'h3333_0002, 1'b0, 1'b0, 32'h0);
        add_step(2, WR, 32'h0000_000C, 4'hF, 32'h4444_0003, 1'b0, 1'b0, 32'h0);
        add_step(2, WR, 32'h0000_0FFC, 4'hF, 32'hDEAD_BEEF, 1'b0, 1'b0, 32'h0);
        add_step(2, RD, 32'h0000_0000, 4'h0, 32'h0, 1'b1, 1'b0, 32'h1111_0000);
        add_step(2, RD, 32'h0000_0004, 4'h0, 32'h0, 1'b1, 1'b0, 32'h2222_0001);
        add_step(2, RD, 32'h0000_0008, 4'h0, 32'h0, 1'b1, 1'b0, 32'h3333_0002);
        add_step(2, RD, 32'h0000_000C, 4'h0, 32'h0, 1'b1, 1'b0, 32'h4444_0003);
        add_step(2, RD, 32'h0000_0FFC, 4'h0, 32'h0, 1'b1, 1'b0, 32'hDEAD_BEEF);
        // Bank 0 row 16, merged lane by lane
        add_step(3, WR, 32'h0000_0100, 4'hF, 32'hAABB_CCDD, 1'b0, 1'b0, 32'h0);
        add_step(3, WR, 32'h0000_0100, 4'h1, 32'h0000_0011, 1'b0, 1'b0, 32'h0);
        add_step(3, WR, 32'h0000_0100, 4'hC, 32'h5566_0000, 1'b0, 1'b0, 32'h0);
        add_step(3, WR, 32'h0000_0100, 4'h0, 32'hFFFF_FFFF, 1'b0, 1'b0, 32'h0);
        add_step(3, RD, 32'h0000_0100, 4'h0, 32'h0, 1'b1, 1'b0, 32'h5566_CC11);
        // Words 8 to 15 span rows 2 and 3 of every bank
        for (int w = 8; w < 16; w++) begin
            add_step(4, WR, 32'(w) << 2, 4'hF, 32'hC0DE_0000 + 32'(w) * 32'h0101,
                     1'b0, 1'b0, 32'h0);
        end
        for (int w = 8; w < 16; w++) begin
            add_step(4, RD, 32'(w) << 2, 4'h0, 32'h0,
                     1'b1, 1'b0, 32'hC0DE_0000 + 32'(w) * 32'h0101);
        end
        // Word 1024 would alias row 0 of bank 0 if truncated
        add_step(5, RD, 32'h0000_1000, 4'h0, 32'h0, 1'b1, 1'b1, 32'h0);
        add_step(5, WR, 32'h0000_1000, 4'hF, 32'hFFFF_FFFF, 1'b1, 1'b1, 32'h0);
        add_step(5, WR, 32'h8000_0000, 4'hF, 32'hFFFF_FFFF, 1'b1, 1'b1, 32'h0);
        add_step(5, RD, 32'h0000_0000, 4'h0, 32'h0, 1'b1, 1'b0, 32'h1111_0000);
    endtask

    // Drive one request on the falling edge
    task automatic issue(input step_t s);
        exp_t         e;
        logic [29:0]  w;
        @(negedge clk_i);
        req.req        = 1'b1;
        req.wen        = s.wen;
        req.add        = s.add;
        req.be         = s.be;
        req.wdata.word = s.wdata;
        w = s.add[31:2];
        if (!s.wen && w < NB_WORDS) begin
            shadow[w] = merge_bytes(shadow.exists(w) ? shadow[w] : 32'h0, s.wdata, s.be);
        end
        // Accepted at the next rising edge, seen after the third
        if (s.rsp) begin
            e.due   = cyc + 3;
            e.err   = s.err;
            e.rdata = s.rdata;
            exp_q.push_back(e);
        end
    endtask

    task automatic idle();
        @(negedge clk_i);
        req.req = 1'b0;
    endtask

    task automatic finish_test(input int id);
        idle();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        $display("Test %0d %s: %0d checks, %0d errors", id, test_name(id),
                 n_checks - chk_base, n_errors - err_base);
        chk_base = n_checks;
        err_base = n_errors;
    endtask

    task automatic run_random();
        step_t        s;
        logic [31:0]  rnd;
        logic [29:0]  w;
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            // Words 0 to 127, so reads often hit earlier writes
            w = 30'(rnd[22:16]);
            s.test  = 6;
            s.wen   = rnd[0];
            s.add   = {w, 2'b00};
            s.be    = rnd[7:4];
            s.wdata = $random(seed);
            // First touch of a word is a full write
            if (!shadow.exists(w)) begin
                s.wen = WR;
                s.be  = 4'hF;
            end
            s.rsp   = s.wen;
            s.err   = 1'b0;
            s.rdata = s.wen ? shadow[w] : 32'h0;
            issue(s);
        end
    endtask

    // Response monitor on the falling edge
    always @(negedge clk_i) begin : monitor
        exp_t e;
        if (resp.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected response pulse at cycle %0d", cyc);
                n_errors++;
            end else begin
                e = exp_q.pop_front();
                n_checks++;
                if (e.due != cyc) begin
                    $display("Response due at cycle %0d arrived at cycle %0d", e.due, cyc);
                    n_errors++;
                end
                if (resp.err !== e.err) begin
                    $display("Mismatch resp.err: got %h, expected %h", resp.err, e.err);
                    n_errors++;
                end
                if (resp.rdata.word !== e.rdata) begin
                    $display("Mismatch resp.rdata: got %h, expected %h",
                             resp.rdata.word, e.rdata);
                    n_errors++;
                end
            end
        end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            e = exp_q.pop_front();
            $display("No response seen for the request due at cycle %0d", e.due);
            n_errors++;
        end
    end

    // Limit scales with the number of requests
    initial begin : watchdog
        wait (rst_n === 1'b1);
        #((steps.size() + N_RAND + 50) * 10);
        $display("Timeout: run still busy with %0d responses outstanding", exp_q.size());
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        int cur;
        rst_n = 1'b0;
        req   = '0;
        build_table();
        // Test 1, no pulse in reset or just after it
        repeat (16) begin
            @(negedge clk_i);
            n_checks++;
            if (resp.valid !== 1'b0) begin
                $display("Mismatch resp.valid: got %h, expected %h", resp.valid, 1'b0);
                n_errors++;
            end
        end
        rst_n = 1'b1;
        repeat (5) begin
            @(negedge clk_i);
            n_checks++;
            if (resp.valid !== 1'b0) begin
                $display("Mismatch resp.valid: got %h, expected %h", resp.valid, 1'b0);
                n_errors++;
            end
        end
        finish_test(1);
        // Table rows, one request per cycle within a test
        cur = steps[0].test;
        foreach (steps[i]) begin
            if (steps[i].test != cur) begin
                finish_test(cur);
                cur = steps[i].test;
            end
            issue(steps[i]);
        end
        finish_test(cur);
        run_random();
        finish_test(6);
        n_errors += UUT.i_props.assert_fails;
        $display("Total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tb.f */
hdl/tcdm_bus_pkg.sv
hdl/tcdm_mem_pkg.sv
hdl/tcdm_req_decode.sv
hdl/tcdm_bank_sram.sv
hdl/tcdm_bank_array.sv
hdl/tcdm_resp_select.sv
hdl/tcdm_subsystem.sv
bench/tcdm_properties.sv
bench/tcdm_tb.sv
